// File: hdl/cgra_geom_pkg.sv
package cgra_geom_pkg;

  // ####################
  // datapath geometry

  localparam int LANE_W = 16;  // one operand lane.
  localparam int LANES  = 4;   // lanes per wide word.
  localparam int WORD_W = LANE_W * LANES;

  // configuration port
  localparam int CFG_W  = 32;

endpackage

// File: hdl/cgra_conf_pkg.sv
package cgra_conf_pkg;

  // ####################
  // processing element setup

  typedef enum logic [1:0] {
    OP_ADD  = 2'd0,
    OP_MUL  = 2'd1,
    OP_SUB  = 2'd2,
    OP_PASS = 2'd3  // forwards operand a.
  } opcode_t;

  typedef enum logic [1:0] {
    SEL_IN0   = 2'd0,
    SEL_IN1   = 2'd1,
    SEL_CONST = 2'd2,
    SEL_ZERO  = 2'd3
  } operand_sel_t;

  // fields of a processing element word
  localparam int OPC_LSB   = 0;
  localparam int SELA_LSB  = 2;
  localparam int SELB_LSB  = 4;
  localparam int CONST_LSB = 16;
  localparam int CONST_W   = cgra_geom_pkg::CFG_W - CONST_LSB;  // upper half.

  // ####################
  // job setup

  localparam int JOB_LEN_W = 16;  // low half of word 0.
  localparam int CFG_WORDS = 3;

  // ####################
  // controller states

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DRAIN,
    ST_DONE
  } exec_state_t;

  typedef enum logic [1:0] {
    LD_IDLE,
    LD_ACK,
    LD_READY  // full setup held.
  } load_state_t;

endpackage

// File: hdl/conf_loader.sv
`timescale 1ns/1ps

module conf_loader (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                i_cfg_req,
  input  logic [cgra_geom_pkg::CFG_W-1:0]     i_cfg_data,
  output logic                                o_cfg_ack,
  output logic [cgra_conf_pkg::JOB_LEN_W-1:0] o_job_len,
  output cgra_conf_pkg::opcode_t              o_op0,
  output cgra_conf_pkg::operand_sel_t         o_sela0,
  output cgra_conf_pkg::operand_sel_t         o_selb0,
  output logic [cgra_conf_pkg::CONST_W-1:0]   o_const0,
  output cgra_conf_pkg::opcode_t              o_op1,
  output cgra_conf_pkg::operand_sel_t         o_sela1,
  output cgra_conf_pkg::operand_sel_t         o_selb1,
  output logic [cgra_conf_pkg::CONST_W-1:0]   o_const1,
  output logic                                o_start
);

  localparam int CNT_W = $clog2(cgra_conf_pkg::CFG_WORDS);

  cgra_conf_pkg::load_state_t ld_state;
  logic [CNT_W-1:0]           word_cnt;   // index of the next word.
  logic                       last_word;
  logic                       accept;

  assign accept = i_cfg_req && (ld_state != cgra_conf_pkg::LD_ACK);

  // ####################
  // four-phase receiver

  always_ff @(posedge clk) begin
    if (rst) begin
      ld_state  <= cgra_conf_pkg::LD_IDLE;
      o_cfg_ack <= 1'b0;
      word_cnt  <= '0;
      last_word <= 1'b0;
      o_start   <= 1'b0;
    end else begin
      last_word <= 1'b0;
      o_start   <= last_word;  // one cycle after the last ack rises.
      if (ld_state == cgra_conf_pkg::LD_ACK) begin
        if (!i_cfg_req) begin
          o_cfg_ack <= 1'b0;
          if (word_cnt == '0) begin
            ld_state <= cgra_conf_pkg::LD_READY;
          end else begin
            ld_state <= cgra_conf_pkg::LD_IDLE;
          end
        end
      end else if (accept) begin
        o_cfg_ack <= 1'b1;
        ld_state  <= cgra_conf_pkg::LD_ACK;
        if (word_cnt == CNT_W'(cgra_conf_pkg::CFG_WORDS - 1)) begin
          word_cnt  <= '0;
          last_word <= 1'b1;
        end else begin
          word_cnt <= word_cnt + 1'b1;
        end
      end
    end
  end

  // ####################
  // field decode

  always_ff @(posedge clk) begin
    if (accept) begin
      case (word_cnt)
        CNT_W'(0): begin
          o_job_len <= i_cfg_data[cgra_conf_pkg::JOB_LEN_W-1:0];
        end
        CNT_W'(1): begin
          o_op0    <= cgra_conf_pkg::opcode_t'(i_cfg_data[cgra_conf_pkg::OPC_LSB +: 2]);
          o_sela0  <= cgra_conf_pkg::operand_sel_t'(i_cfg_data[cgra_conf_pkg::SELA_LSB +: 2]);
          o_selb0  <= cgra_conf_pkg::operand_sel_t'(i_cfg_data[cgra_conf_pkg::SELB_LSB +: 2]);
          o_const0 <= i_cfg_data[cgra_conf_pkg::CONST_LSB +: cgra_conf_pkg::CONST_W];
        end
        default: begin
          o_op1    <= cgra_conf_pkg::opcode_t'(i_cfg_data[cgra_conf_pkg::OPC_LSB +: 2]);
          o_sela1  <= cgra_conf_pkg::operand_sel_t'(i_cfg_data[cgra_conf_pkg::SELA_LSB +: 2]);
          o_selb1  <= cgra_conf_pkg::operand_sel_t'(i_cfg_data[cgra_conf_pkg::SELB_LSB +: 2]);
          o_const1 <= i_cfg_data[cgra_conf_pkg::CONST_LSB +: cgra_conf_pkg::CONST_W];
        end
      endcase
    end
  end

  a_cfg_data_stable: assert property (@(posedge clk) disable iff (rst)
    i_cfg_req && $past(i_cfg_req) |-> $stable(i_cfg_data));

endmodule

// File: hdl/stream_unpack.sv
`timescale 1ns/1ps

module stream_unpack #(
  parameter int LANE_W = cgra_geom_pkg::LANE_W,
  parameter int LANES  = cgra_geom_pkg::LANES
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_req,
  input  logic [LANE_W*LANES-1:0] i_data,
  input  logic                    i_pop,
  output logic                    o_ack,
  output logic                    o_avail,
  output logic [LANE_W-1:0]       o_lane
);

  localparam int WORD_W = LANE_W * LANES;

  logic [WORD_W-1:0] word_q;
  logic [LANES-1:0]  lane_cnt;  // one-hot, lane being handed out.
  logic              loaded;
  logic              empty;
  logic              take;

  assign empty  = !o_avail && !loaded;
  assign take   = i_req && !o_ack && empty;
  assign o_lane = word_q[LANE_W-1:0];  // lowest lane first.

  always_ff @(posedge clk) begin
    if (rst) begin
      o_ack  <= 1'b0;
      loaded <= 1'b0;
    end else begin
      loaded <= take;
      if (take) begin
        o_ack <= 1'b1;
      end else if (o_ack && !i_req) begin
        o_ack <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_avail  <= 1'b0;
      lane_cnt <= '0;
    end else if (loaded) begin
      o_avail  <= 1'b1;
      lane_cnt <= LANES'(1);
    end else if (i_pop) begin
      lane_cnt <= lane_cnt << 1;
      if (lane_cnt[LANES-1]) begin
        o_avail <= 1'b0;  // word used up.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      word_q <= i_data;
    end else if (i_pop) begin
      word_q <= word_q >> LANE_W;
    end
  end

  a_pop_needs_avail: assert property (@(posedge clk) disable iff (rst)
    i_pop |-> o_avail);

endmodule

// File: hdl/exec_control.sv
`timescale 1ns/1ps

module exec_control (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                i_start,
  input  logic [cgra_conf_pkg::JOB_LEN_W-1:0] i_job_len,
  input  logic                                i_avail_a,
  input  logic                                i_avail_b,
  input  logic                                i_pack_ready,
  input  logic                                i_pack_lanes_done,
  output logic                                o_en,
  output logic                                o_pop,
  output logic                                o_valid_in,
  output logic                                o_done
);

  localparam int LANES = cgra_geom_pkg::LANES;
  localparam int CNT_W = cgra_conf_pkg::JOB_LEN_W + $clog2(LANES) + 1;

  cgra_conf_pkg::exec_state_t state;
  logic [CNT_W-1:0]           total_q;    // lanes in this job.
  logic [CNT_W-1:0]           popped;
  logic [CNT_W-1:0]           delivered;
  logic                       lanes_left;
  logic                       drain_left;

  assign lanes_left = (popped != total_q);
  assign drain_left = (delivered != total_q);

  assign o_pop      = (state == cgra_conf_pkg::ST_RUN) && lanes_left &&
                      i_avail_a && i_avail_b && i_pack_ready;
  assign o_valid_in = o_pop;
  assign o_en       = o_pop ||
                      ((state == cgra_conf_pkg::ST_DRAIN) && drain_left && i_pack_ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= cgra_conf_pkg::ST_IDLE;
      total_q   <= '0;
      popped    <= '0;
      delivered <= '0;
      o_done    <= 1'b0;
    end else begin
      if (o_pop) begin
        popped <= popped + 1'b1;
      end
      if (i_pack_lanes_done) begin
        delivered <= delivered + 1'b1;
      end
      case (state)
        cgra_conf_pkg::ST_RUN: begin
          if (!lanes_left) begin
            state <= cgra_conf_pkg::ST_DRAIN;
          end
        end
        cgra_conf_pkg::ST_DRAIN: begin
          if (!drain_left && i_pack_ready) begin  // last word handed off.
            state  <= cgra_conf_pkg::ST_DONE;
            o_done <= 1'b1;
          end
        end
        default: begin
          if (i_start) begin
            total_q   <= CNT_W'(i_job_len) * CNT_W'(LANES);
            popped    <= '0;
            delivered <= '0;
            o_done    <= 1'b0;
            state     <= cgra_conf_pkg::ST_RUN;
          end
        end
      endcase
    end
  end

  a_no_lane_before_pop: assert property (@(posedge clk) disable iff (rst)
    delivered <= popped);

endmodule

// File: hdl/pe_stage.sv
`timescale 1ns/1ps

module pe_stage #(
  parameter int LANE_W = cgra_geom_pkg::LANE_W
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        i_en,
  input  logic                        i_valid,
  input  logic [LANE_W-1:0]           i_in0,
  input  logic [LANE_W-1:0]           i_in1,
  input  cgra_conf_pkg::opcode_t      i_op,
  input  cgra_conf_pkg::operand_sel_t i_sel_a,
  input  cgra_conf_pkg::operand_sel_t i_sel_b,
  input  logic [LANE_W-1:0]           i_const,
  output logic                        o_valid,
  output logic [LANE_W-1:0]           o_result,
  output logic [LANE_W-1:0]           o_in1_q
);

  logic [LANE_W-1:0] op_a;
  logic [LANE_W-1:0] op_b;
  logic [LANE_W-1:0] alu_out;

  function automatic logic [LANE_W-1:0] pick(input cgra_conf_pkg::operand_sel_t sel,
                                             input logic [LANE_W-1:0] in0,
                                             input logic [LANE_W-1:0] in1,
                                             input logic [LANE_W-1:0] cval);
    case (sel)
      cgra_conf_pkg::SEL_IN0:   return in0;
      cgra_conf_pkg::SEL_IN1:   return in1;
      cgra_conf_pkg::SEL_CONST: return cval;
      default:                  return '0;
    endcase
  endfunction

  assign op_a = pick(i_sel_a, i_in0, i_in1, i_const);
  assign op_b = pick(i_sel_b, i_in0, i_in1, i_const);

  always_comb begin
    case (i_op)
      cgra_conf_pkg::OP_ADD: alu_out = op_a + op_b;
      cgra_conf_pkg::OP_MUL: alu_out = op_a * op_b;  // low half kept.
      cgra_conf_pkg::OP_SUB: alu_out = op_a - op_b;
      default:               alu_out = op_a;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_valid <= 1'b0;
    end else if (i_en) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_en) begin
      o_result <= alu_out;
      o_in1_q  <= i_in1;
    end
  end

endmodule

// File: hdl/stream_pack.sv
`timescale 1ns/1ps

module stream_pack #(
  parameter int LANE_W = cgra_geom_pkg::LANE_W,
  parameter int LANES  = cgra_geom_pkg::LANES
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_en,
  input  logic                    i_valid,
  input  logic [LANE_W-1:0]       i_lane,
  input  logic                    i_out_ack,
  output logic                    o_ready,
  output logic                    o_lane_taken,
  output logic                    o_out_req,
  output logic [LANE_W*LANES-1:0] o_out_data
);

  localparam int WORD_W = LANE_W * LANES;

  logic [WORD_W-1:0] word_q;
  logic [LANES-1:0]  lane_cnt;  // one-hot slot for the next lane.

  assign o_lane_taken = i_en && i_valid;
  assign o_out_data   = word_q;

  // lanes enter at the top, so the first one ends up lowest.
  always_ff @(posedge clk) begin
    if (o_lane_taken) begin
      word_q <= {i_lane, word_q[WORD_W-1:LANE_W]};
    end
  end

  // ####################
  // four-phase sender

  always_ff @(posedge clk) begin
    if (rst) begin
      o_ready   <= 1'b1;
      o_out_req <= 1'b0;
      lane_cnt  <= LANES'(1);
    end else begin
      if (o_lane_taken) begin
        if (lane_cnt[LANES-1]) begin
          lane_cnt  <= LANES'(1);
          o_ready   <= 1'b0;
          o_out_req <= 1'b1;  // word complete.
        end else begin
          lane_cnt <= lane_cnt << 1;
        end
      end
      if (o_out_req && i_out_ack) begin
        o_out_req <= 1'b0;
      end else if (!o_out_req && !o_ready && !i_out_ack) begin
        o_ready <= 1'b1;  // ack is back low.
      end
    end
  end

  a_data_stable: assert property (@(posedge clk) disable iff (rst)
    o_out_req && $past(o_out_req) |-> $stable(o_out_data));

endmodule

// File: hdl/cgra_acc.sv
`timescale 1ns/1ps

module cgra_acc #(
  parameter int LANE_W = cgra_geom_pkg::LANE_W,
  parameter int LANES  = cgra_geom_pkg::LANES
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            i_cfg_req,
  input  logic [cgra_geom_pkg::CFG_W-1:0] i_cfg_data,
  output logic                            o_cfg_ack,
  input  logic                            i_a_req,
  input  logic [LANE_W*LANES-1:0]         i_a_data,
  output logic                            o_a_ack,
  input  logic                            i_b_req,
  input  logic [LANE_W*LANES-1:0]         i_b_data,
  output logic                            o_b_ack,
  output logic                            o_out_req,
  output logic [LANE_W*LANES-1:0]         o_out_data,
  input  logic                            i_out_ack,
  output logic                            o_done
);

  // job setup
  logic [cgra_conf_pkg::JOB_LEN_W-1:0] job_len;
  cgra_conf_pkg::opcode_t              op0;
  cgra_conf_pkg::operand_sel_t         sela0;
  cgra_conf_pkg::operand_sel_t         selb0;
  cgra_conf_pkg::opcode_t              op1;
  cgra_conf_pkg::operand_sel_t         sela1;
  cgra_conf_pkg::operand_sel_t         selb1;
  logic [cgra_conf_pkg::CONST_W-1:0]   const0_cfg;
  logic [cgra_conf_pkg::CONST_W-1:0]   const1_cfg;
  logic [LANE_W-1:0]                   const0;
  logic [LANE_W-1:0]                   const1;
  logic                                start;

  // streams and control
  logic              avail_a;
  logic              avail_b;
  logic [LANE_W-1:0] lane_a;
  logic [LANE_W-1:0] lane_b;
  logic              pop;
  logic              en;
  logic              valid_in;
  logic              pack_ready;
  logic              lane_taken;

  // element chain
  logic              pe0_valid;
  logic [LANE_W-1:0] pe0_result;
  logic [LANE_W-1:0] pe0_b_q;
  logic              pe1_valid;
  logic [LANE_W-1:0] pe1_result;

  assign const0 = LANE_W'(const0_cfg);
  assign const1 = LANE_W'(const1_cfg);

  conf_loader i_conf_loader (
    .clk        (clk),
    .rst        (rst),
    .i_cfg_req  (i_cfg_req),
    .i_cfg_data (i_cfg_data),
    .o_cfg_ack  (o_cfg_ack),
    .o_job_len  (job_len),
    .o_op0      (op0),
    .o_sela0    (sela0),
    .o_selb0    (selb0),
    .o_const0   (const0_cfg),
    .o_op1      (op1),
    .o_sela1    (sela1),
    .o_selb1    (selb1),
    .o_const1   (const1_cfg),
    .o_start    (start)
  );

  stream_unpack #(.LANE_W(LANE_W), .LANES(LANES)) i_unpack_a (
    .clk     (clk),
    .rst     (rst),
    .i_req   (i_a_req),
    .i_data  (i_a_data),
    .i_pop   (pop),
    .o_ack   (o_a_ack),
    .o_avail (avail_a),
    .o_lane  (lane_a)
  );

  stream_unpack #(.LANE_W(LANE_W), .LANES(LANES)) i_unpack_b (
    .clk     (clk),
    .rst     (rst),
    .i_req   (i_b_req),
    .i_data  (i_b_data),
    .i_pop   (pop),
    .o_ack   (o_b_ack),
    .o_avail (avail_b),
    .o_lane  (lane_b)
  );

  exec_control i_exec_control (
    .clk               (clk),
    .rst               (rst),
    .i_start           (start),
    .i_job_len         (job_len),
    .i_avail_a         (avail_a),
    .i_avail_b         (avail_b),
    .i_pack_ready      (pack_ready),
    .i_pack_lanes_done (lane_taken),
    .o_en              (en),
    .o_pop             (pop),
    .o_valid_in        (valid_in),
    .o_done            (o_done)
  );

  pe_stage #(.LANE_W(LANE_W)) i_pe0 (
    .clk      (clk),
    .rst      (rst),
    .i_en     (en),
    .i_valid  (valid_in),
    .i_in0    (lane_a),
    .i_in1    (lane_b),
    .i_op     (op0),
    .i_sel_a  (sela0),
    .i_sel_b  (selb0),
    .i_const  (const0),
    .o_valid  (pe0_valid),
    .o_result (pe0_result),
    .o_in1_q  (pe0_b_q)
  );

  // b lane rides along with element 0's result.
  pe_stage #(.LANE_W(LANE_W)) i_pe1 (
    .clk      (clk),
    .rst      (rst),
    .i_en     (en),
    .i_valid  (pe0_valid),
    .i_in0    (pe0_result),
    .i_in1    (pe0_b_q),
    .i_op     (op1),
    .i_sel_a  (sela1),
    .i_sel_b  (selb1),
    .i_const  (const1),
    .o_valid  (pe1_valid),
    .o_result (pe1_result),
    .o_in1_q  ()
  );

  stream_pack #(.LANE_W(LANE_W), .LANES(LANES)) i_stream_pack (
    .clk          (clk),
    .rst          (rst),
    .i_en         (en),
    .i_valid      (pe1_valid),
    .i_lane       (pe1_result),
    .i_out_ack    (i_out_ack),
    .o_ready      (pack_ready),
    .o_lane_taken (lane_taken),
    .o_out_req    (o_out_req),
    .o_out_data   (o_out_data)
  );

endmodule

// File: bench/cgra_checker.sv
`timescale 1ns/1ps

module cgra_checker #(
  parameter int LANE_W = cgra_geom_pkg::LANE_W,
  parameter int LANES  = cgra_geom_pkg::LANES
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            i_cfg_ack,
  input  logic [cgra_geom_pkg::CFG_W-1:0] i_cfg_data,
  input  logic                            i_a_ack,
  input  logic [LANE_W*LANES-1:0]         i_a_data,
  input  logic                            i_b_ack,
  input  logic [LANE_W*LANES-1:0]         i_b_data,
  input  logic                            i_out_req,
  input  logic                            i_out_ack,
  input  logic [LANE_W*LANES-1:0]         i_out_data,
  input  logic                            i_done,
  output int                              o_err_cnt,
  output int                              o_word_cnt
);

  localparam int WORD_W = LANE_W * LANES;

  logic [WORD_W-1:0] a_q [$];  // words taken by the DUT, oldest first.
  logic [WORD_W-1:0] b_q [$];
  logic [31:0]       cfg_w [3];
  int                cfg_idx;
  int                err_cnt  = 0;
  int                word_cnt = 0;
  logic              rst_q    = 1'b0;
  logic              cfg_ack_q;
  logic              a_ack_q;
  logic              b_ack_q;
  logic              out_ack_q;
  logic              done_q;

  function automatic logic [LANE_W-1:0] select_operand(input logic [1:0] sel,
                                                       input logic [LANE_W-1:0] in0,
                                                       input logic [LANE_W-1:0] in1,
                                                       input logic [LANE_W-1:0] cval);
    case (sel)
      2'd0:    return in0;
      2'd1:    return in1;
      2'd2:    return cval;
      default: return '0;
    endcase
  endfunction

  function automatic logic [LANE_W-1:0] apply_op(input logic [1:0] op,
                                                 input logic [LANE_W-1:0] x,
                                                 input logic [LANE_W-1:0] y);
    case (op)
      2'd0:    return x + y;
      2'd1:    return x * y;  // low half only.
      2'd2:    return x - y;
      default: return x;
    endcase
  endfunction

  // one lane through both elements.
  function automatic logic [LANE_W-1:0] ref_lane(input logic [LANE_W-1:0] a,
                                                 input logic [LANE_W-1:0] b,
                                                 input logic [31:0] w1,
                                                 input logic [31:0] w2);
    logic [LANE_W-1:0] c0;
    logic [LANE_W-1:0] c1;
    logic [LANE_W-1:0] r0;
    c0 = LANE_W'(w1[31:16]);
    c1 = LANE_W'(w2[31:16]);
    r0 = apply_op(w1[1:0], select_operand(w1[3:2], a, b, c0),
                  select_operand(w1[5:4], a, b, c0));
    return apply_op(w2[1:0], select_operand(w2[3:2], r0, b, c1),
                    select_operand(w2[5:4], r0, b, c1));
  endfunction

  function automatic logic [WORD_W-1:0] ref_word(input logic [WORD_W-1:0] a,
                                                 input logic [WORD_W-1:0] b);
    logic [WORD_W-1:0] w;
    for (int l = 0; l < LANES; l++) begin
      w[l*LANE_W +: LANE_W] = ref_lane(a[l*LANE_W +: LANE_W], b[l*LANE_W +: LANE_W],
                                       cfg_w[1], cfg_w[2]);
    end
    return w;
  endfunction

  // ####################
  // port watch

  always @(posedge clk) begin : watch
    logic [WORD_W-1:0] a_word;
    logic [WORD_W-1:0] b_word;
    logic [WORD_W-1:0] expected;
    if (rst) begin
      cfg_idx = 0;
      a_q.delete();
      b_q.delete();
    end else begin
      if (rst_q && (i_cfg_ack || i_a_ack || i_b_ack || i_out_req || i_done)) begin
        $display("Error at %0t: outputs not idle after reset", $time);
        err_cnt++;
      end
      if (i_cfg_ack && !cfg_ack_q) begin
        cfg_w[cfg_idx] = i_cfg_data;
        cfg_idx = (cfg_idx + 1) % 3;
      end
      if (i_a_ack && !a_ack_q) begin
        a_q.push_back(i_a_data);
      end
      if (i_b_ack && !b_ack_q) begin
        b_q.push_back(i_b_data);
      end
      if (i_out_req && i_out_ack && !out_ack_q) begin
        if (a_q.size() == 0 || b_q.size() == 0) begin
          $display("output word %h at %0t has no input words behind it", i_out_data, $time);
          err_cnt++;
        end else begin
          a_word   = a_q.pop_front();
          b_word   = b_q.pop_front();
          expected = ref_word(a_word, b_word);
          word_cnt++;
          if (i_out_data !== expected) begin
            $display("Error at %0t: output word %0d is %h, expected %h",
                     $time, word_cnt, i_out_data, expected);
            err_cnt++;
          end
        end
      end
      if (i_done && !done_q && (a_q.size() != 0 || b_q.size() != 0)) begin
        $display("done rose at %0t while %0d A and %0d B words never came out",
                 $time, a_q.size(), b_q.size());
        err_cnt++;
      end
    end
    rst_q      = rst;
    cfg_ack_q  = i_cfg_ack;
    a_ack_q    = i_a_ack;
    b_ack_q    = i_b_ack;
    out_ack_q  = i_out_ack;
    done_q     = i_done;
    o_err_cnt  <= err_cnt;
    o_word_cnt <= word_cnt;
  end

endmodule

// File: bench/tb_cgra_acc.sv
`timescale 1ns/1ps

module tb_cgra_acc;

  localparam int LANE_W    = cgra_geom_pkg::LANE_W;
  localparam int LANES     = cgra_geom_pkg::LANES;
  localparam int WORD_W    = LANE_W * LANES;
  localparam int MAX_WORDS = 8;
  localparam int LIMIT     = 300;  // cycles allowed per wait.

  localparam int SIG_CFG_ACK = 0;
  localparam int SIG_A_ACK   = 1;
  localparam int SIG_B_ACK   = 2;
  localparam int SIG_OUT_REQ = 3;
  localparam int SIG_DONE    = 4;

  logic                            clk;
  logic                            rst;
  logic                            i_cfg_req;
  logic [cgra_geom_pkg::CFG_W-1:0] i_cfg_data;
  logic                            o_cfg_ack;
  logic                            i_a_req;
  logic [WORD_W-1:0]               i_a_data;
  logic                            o_a_ack;
  logic                            i_b_req;
  logic [WORD_W-1:0]               i_b_data;
  logic                            o_b_ack;
  logic                            o_out_req;
  logic [WORD_W-1:0]               o_out_data;
  logic                            i_out_ack;
  logic                            o_done;

  integer            seed;
  logic              timed_out = 1'b0;
  int                test_cnt  = 0;
  int                test_fail = 0;
  int                err_cnt;
  int                word_cnt;
  logic [WORD_W-1:0] a_words [MAX_WORDS];
  logic [WORD_W-1:0] b_words [MAX_WORDS];
  int                a_gap [MAX_WORDS];
  int                b_gap [MAX_WORDS];
  int                ack_gap [MAX_WORDS];

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  cgra_acc #(.LANE_W(LANE_W), .LANES(LANES)) i_cgra_acc (
    .clk(clk), .rst(rst),
    .i_cfg_req(i_cfg_req), .i_cfg_data(i_cfg_data), .o_cfg_ack(o_cfg_ack),
    .i_a_req(i_a_req), .i_a_data(i_a_data), .o_a_ack(o_a_ack),
    .i_b_req(i_b_req), .i_b_data(i_b_data), .o_b_ack(o_b_ack),
    .o_out_req(o_out_req), .o_out_data(o_out_data), .i_out_ack(i_out_ack),
    .o_done(o_done)
  );

  cgra_checker #(.LANE_W(LANE_W), .LANES(LANES)) i_checker (
    .clk(clk), .rst(rst),
    .i_cfg_ack(o_cfg_ack), .i_cfg_data(i_cfg_data),
    .i_a_ack(o_a_ack), .i_a_data(i_a_data), .i_b_ack(o_b_ack), .i_b_data(i_b_data),
    .i_out_req(o_out_req), .i_out_ack(i_out_ack), .i_out_data(o_out_data),
    .i_done(o_done), .o_err_cnt(err_cnt), .o_word_cnt(word_cnt)
  );

  function automatic logic port_level(input int which);
    case (which)
      SIG_CFG_ACK: return o_cfg_ack;
      SIG_A_ACK:   return o_a_ack;
      SIG_B_ACK:   return o_b_ack;
      SIG_OUT_REQ: return o_out_req;
      default:     return o_done;
    endcase
  endfunction

  task automatic await_level(input int which, input logic level, input string what);
    int cnt;
    cnt = 0;
    while (port_level(which) != level && !timed_out) begin
      @(posedge clk);
      cnt++;
      if (cnt > LIMIT) begin
        $display("timeout at %0t: %s did not go %0b", $time, what, level);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic send_cfg(input logic [31:0] word);
    @(posedge clk);
    i_cfg_req  <= 1'b1;
    i_cfg_data <= word;
    await_level(SIG_CFG_ACK, 1'b1, "configuration ack");
    i_cfg_req <= 1'b0;
    await_level(SIG_CFG_ACK, 1'b0, "configuration ack");
  endtask

  task automatic send_a(input int n);
    for (int i = 0; i < n; i++) begin
      repeat (a_gap[i]) @(posedge clk);
      @(posedge clk);
      i_a_req  <= 1'b1;
      i_a_data <= a_words[i];
      await_level(SIG_A_ACK, 1'b1, "stream A ack");
      i_a_req <= 1'b0;
      await_level(SIG_A_ACK, 1'b0, "stream A ack");
    end
  endtask

  task automatic send_b(input int n);
    for (int i = 0; i < n; i++) begin
      repeat (b_gap[i]) @(posedge clk);
      @(posedge clk);
      i_b_req  <= 1'b1;
      i_b_data <= b_words[i];
      await_level(SIG_B_ACK, 1'b1, "stream B ack");
      i_b_req <= 1'b0;
      await_level(SIG_B_ACK, 1'b0, "stream B ack");
    end
  endtask

  task automatic take_outputs(input int n);
    for (int i = 0; i < n; i++) begin
      await_level(SIG_OUT_REQ, 1'b1, "output req");
      repeat (ack_gap[i]) @(posedge clk);
      i_out_ack <= 1'b1;
      await_level(SIG_OUT_REQ, 1'b0, "output req");
      i_out_ack <= 1'b0;
    end
  endtask

  task automatic report_test(input string name, input int err0, input int words0,
                             input int n);
    int errs;
    int words;
    errs  = err_cnt - err0;
    words = word_cnt - words0;
    test_cnt++;
    if (errs != 0 || words != n || timed_out) begin
      test_fail++;
      $display("test %0d %s: failed, %0d of %0d words checked, %0d errors",
               test_cnt, name, words, n, errs);
    end else begin
      $display("test %0d %s: ok, %0d words checked", test_cnt, name, words);
    end
  endtask

  // whole job: setup, both streams, output side, then done.
  task automatic run_job(input string name, input int n, input logic [31:0] w1,
                         input logic [31:0] w2, input int a_mask, input int b_mask,
                         input int ack_mask);
    int err0;
    int words0;
    err0   = err_cnt;
    words0 = word_cnt;
    for (int i = 0; i < n; i++) begin
      for (int l = 0; l < LANES; l++) begin
        a_words[i][l*LANE_W +: LANE_W] = LANE_W'($random(seed));
        b_words[i][l*LANE_W +: LANE_W] = LANE_W'($random(seed));
      end
      a_gap[i]   = $random(seed) & a_mask;
      b_gap[i]   = $random(seed) & b_mask;
      ack_gap[i] = $random(seed) & ack_mask;
    end
    send_cfg(32'(n));
    send_cfg(w1);
    send_cfg(w2);
    await_level(SIG_DONE, 1'b0, "done clear");
    fork
      send_a(n);
      send_b(n);
      take_outputs(n);
    join
    await_level(SIG_DONE, 1'b1, "done");
    repeat (2) @(posedge clk);
    report_test(name, err0, words0, n);
  endtask

  initial begin
    seed       = 32'h4f55_caf6;
    rst        = 1'b1;
    i_cfg_req  = 1'b0;
    i_cfg_data = '0;
    i_a_req    = 1'b0;
    i_a_data   = '0;
    i_b_req    = 1'b0;
    i_b_data   = '0;
    i_out_ack  = 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);
    report_test("reset state", 0, 0, 0);

    // ####################
    // jobs
    run_job("add stream", 4, 32'h0000_0010, 32'h0000_0003, 0, 0, 0);
    run_job("mul and sub with constants", 6, 32'h0013_0021, 32'h1234_000E, 0, 0, 0);
    run_job("output back-pressure", 5, 32'h0101_0020, 32'h0000_0011, 0, 0, 7);
    run_job("uneven input gaps", 6, 32'h0000_0006, 32'h00ff_0020, 7, 3, 0);
    run_job("reconfigure after done", 3, 32'h0000_0007, 32'h0000_0011, 1, 1, 1);

    $display("tests run %0d, failed %0d, words checked %0d, errors %0d",
             test_cnt, test_fail, word_cnt, err_cnt);
    if (test_fail == 0 && err_cnt == 0 && !timed_out) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: cgra_acc.f
hdl/cgra_geom_pkg.sv
hdl/cgra_conf_pkg.sv
hdl/conf_loader.sv
hdl/stream_unpack.sv
hdl/exec_control.sv
hdl/pe_stage.sv
hdl/stream_pack.sv
hdl/cgra_acc.sv
bench/cgra_checker.sv
bench/tb_cgra_acc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the cgra_acc testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f cgra_acc.f --top-module tb_cgra_acc \
  -Mdir "$BUILD_DIR" -o sim_cgra_acc
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"./$BUILD_DIR/sim_cgra_acc" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF ">>> FAIL" "$LOG"; then
  exit 1
fi
exit 0
